// File: compile.f
+incdir+.
lsuPkg.sv
loadStoreQueue.sv
dcache.sv
memCtrl.sv
dataRam.sv
lsuTop.sv
lsu_chk.sv
tbLsuTop.sv

// File: tbLsuTop.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module tbLsuTop import lsuPkg::*; ();

    localparam int RAND_REQS      = 12;
    localparam int NUM_REQS       = 18 + 4 * RAND_REQS;   // directed plus four random phases.
    localparam int TIMEOUT_CYCLES = 40 * NUM_REQS + 200;

    logic     clk;
    logic     rst;
    logic     rdy;
    logic     fetchBusy;
    logic     reqValid;
    memReq_t  reqIn;
    logic     full;
    logic     respValid;
    memResp_t respOut;

    integer     seed;
    logic       stallRdy;
    logic       stallFetch;
    logic       sawFull;
    logic [3:0] nextNick;
    int         cycles;
    int         pushCycle;
    int         lastRespCycle;
    int         reqCount;
    int         respCount;
    logic [7:0] refMem [`RAM_BYTES];   // byte model of the data RAM.
    memResp_t   expected [$];
    memResp_t   expResp;
    logic [2:0] lens [3];

    lsuTop u_lsuTop (
        .clk(clk), .rst(rst), .rdy(rdy), .fetchBusy(fetchBusy),
        .reqValid(reqValid), .reqIn(reqIn), .full(full),
        .respValid(respValid), .respOut(respOut)
    );

    bind lsuTop lsu_chk u_chk (
        .clk(clk), .rst(rst), .respValid(respValid), .slbEn(slbEn),
        .mcEn(mcEn), .reqValid(reqValid), .full(full)
    );

    always #5 clk = ~clk;

    // ####################
    // helpers.
    // ####################

    task automatic abortRun();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic valueMismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        abortRun();
    endtask

    // loads return zero-extended little-endian bytes, stores echo their data.
    function automatic memResp_t refAccess(memReq_t req);
        memResp_t resp;
        int       idx;
        resp.nick = req.nick;
        resp.data = '0;
        for (int k = 0; k < int'(req.len); k++) begin
            idx = (int'(req.addr) + k) % `RAM_BYTES;   // RAM wraps.
            if (req.op == OP_STORE) begin
                refMem[idx] = req.data[8*k +: 8];
            end else begin
                resp.data[8*k +: 8] = refMem[idx];
            end
        end
        if (req.op == OP_STORE) begin
            resp.data = req.data;
        end
        return resp;
    endfunction

    // one cycle from push to issue, then len+3 or len+4.
    function automatic int expectedLatency(lsOp_t op, int len);
        return 1 + len + 3 + ((op == OP_LOAD) ? 1 : 0);
    endfunction

    task automatic stepCycle();
        @(negedge clk);
        rdy       = stallRdy ? (($random(seed) & 3) != 0) : 1'b1;
        fetchBusy = stallFetch ? (($random(seed) & 3) == 0) : 1'b0;
    endtask

    task automatic sendRequest(lsOp_t op, logic [15:0] addr, logic [31:0] data,
                               logic [2:0] len);
        memReq_t     req;
        logic        accepted;
        logic [31:0] mask;
        case (len)
            3'd1: mask = 32'h0000_00ff;
            3'd2: mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase
        req.op   = op;
        req.addr = addr;
        req.data = (op == OP_STORE) ? (data & mask) : '0;
        req.len  = len;
        req.nick = nextNick;
        while (full) begin
            sawFull = 1'b1;
            stepCycle();
        end
        reqValid = 1'b1;
        reqIn    = req;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = rdy;   // full cannot rise while this push waits.
            if (!accepted) begin
                stepCycle();
            end
        end
        pushCycle = cycles;
        expected.push_back(refAccess(req));
        nextNick = nextNick + 1'b1;
        reqCount++;
        stepCycle();
        reqValid = 1'b0;
    endtask

    task automatic sendRandom();
        logic [31:0] r;
        logic [15:0] addr;
        logic [2:0]  len;
        r = $random(seed);
        case (r[1:0])
            2'd0: len = 3'd1;
            2'd1: len = 3'd2;
            default: len = 3'd4;
        endcase
        addr = 16'h0200 + {10'd0, r[8:3]};   // small window so accesses overlap.
        if (len == 3'd2) begin
            addr[0] = 1'b0;
        end else if (len == 3'd4) begin
            addr[1:0] = 2'b00;
        end
        sendRequest(r[2] ? OP_STORE : OP_LOAD, addr, $random(seed), len);
    endtask

    task automatic waitIdle();
        while (expected.size() != 0) begin
            stepCycle();
        end
    endtask

    task automatic runRandom(logic withRdy, logic withFetch);
        stallRdy   = withRdy;
        stallFetch = withFetch;
        repeat (RAND_REQS) sendRandom();
        waitIdle();
        stallRdy   = 1'b0;
        stallFetch = 1'b0;
    endtask

    task automatic checkLatency(lsOp_t op, logic [2:0] len);
        assert (lastRespCycle - pushCycle == expectedLatency(op, len))
            else valueMismatch("latency", lastRespCycle - pushCycle, expectedLatency(op, len));
    endtask

    // ####################
    // cycle count and compare.
    // ####################

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abortRun();
        end
    end

    always @(posedge clk) begin
        assert (u_lsuTop.u_chk.failCount == 0) else begin
            $display("ERROR: a bound protocol assertion failed");
            abortRun();
        end
        if (!rst) begin
            if (!rdy) begin
                assert (!respValid) else begin
                    $display("ERROR: respValid pulsed while rdy was low");
                    abortRun();
                end
            end
            if (respValid) begin
                assert (expected.size() > 0) else begin
                    $display("ERROR: response arrived with no request outstanding");
                    abortRun();
                end
                expResp = expected.pop_front();   // responses come in issue order.
                assert (respOut.nick == expResp.nick)
                    else valueMismatch("respOut.nick", respOut.nick, expResp.nick);
                assert (respOut.data == expResp.data)
                    else valueMismatch("respOut.data", respOut.data, expResp.data);
                lastRespCycle = cycles;
                respCount++;
            end
        end
    end

    // ####################
    // stimulus.
    // ####################

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        rdy        = 1'b0;   // keeps respValid defined before the first edge.
        fetchBusy  = 1'b0;
        reqValid   = 1'b0;
        reqIn      = '0;
        seed       = 32'h8d25_6ca6;
        stallRdy   = 1'b0;
        stallFetch = 1'b0;
        sawFull    = 1'b0;
        nextNick   = '0;
        cycles     = 0;
        reqCount   = 0;
        respCount  = 0;
        lens       = '{3'd1, 3'd2, 3'd4};
        for (int i = 0; i < `RAM_BYTES; i++) begin
            refMem[i] = 8'h00;
        end

        @(negedge clk);
        rdy = 1'b1;   // from here only the reset keeps respValid low.
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        stepCycle();
        assert (!full) else valueMismatch("full", full, 0);
        assert (!respValid) else valueMismatch("respValid", respValid, 0);

        // store then load back each length.
        sendRequest(OP_STORE, 16'h0010, 32'h0000_00a5, 3'd1);
        sendRequest(OP_LOAD,  16'h0010, 32'h0, 3'd1);
        sendRequest(OP_STORE, 16'h0020, 32'h0000_beef, 3'd2);
        sendRequest(OP_LOAD,  16'h0020, 32'h0, 3'd2);
        sendRequest(OP_STORE, 16'h0030, 32'hdead_c0de, 3'd4);
        sendRequest(OP_LOAD,  16'h0030, 32'h0, 3'd4);
        waitIdle();

        // overlapping stores merge. 0x80 is never written.
        sendRequest(OP_STORE, 16'h0040, 32'h1122_3344, 3'd4);
        sendRequest(OP_STORE, 16'h0041, 32'h0000_00aa, 3'd1);
        sendRequest(OP_STORE, 16'h0042, 32'h0000_bbcc, 3'd2);
        sendRequest(OP_LOAD,  16'h0040, 32'h0, 3'd4);
        sendRequest(OP_LOAD,  16'h0080, 32'h0, 3'd4);
        sendRequest(OP_LOAD,  16'h0042, 32'h0, 3'd2);
        waitIdle();

        // unstalled latency, one request at a time.
        for (int i = 0; i < 3; i++) begin
            sendRequest(OP_STORE, 16'h0100, 32'h5a3c_c3a5, lens[i]);
            waitIdle();
            checkLatency(OP_STORE, lens[i]);
            sendRequest(OP_LOAD, 16'h0100, 32'h0, lens[i]);
            waitIdle();
            checkLatency(OP_LOAD, lens[i]);
        end

        // burst that fills the queue.
        sawFull = 1'b0;
        runRandom(1'b0, 1'b0);
        assert (sawFull) else begin
            $display("ERROR: queue never reported full during the burst");
            abortRun();
        end

        runRandom(1'b1, 1'b0);
        runRandom(1'b0, 1'b1);
        runRandom(1'b1, 1'b1);
        repeat (4) stepCycle();

        if (reqCount == NUM_REQS && respCount == reqCount && expected.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("ERROR: %0d requests sent but %0d responses seen", reqCount, respCount);
            abortRun();
        end
    end

endmodule

// File: lsu_chk.sv
`timescale 1ns/1ps

module lsu_chk (
    input logic clk,
    input logic rst,
    input logic respValid,
    input logic slbEn,
    input logic mcEn,
    input logic reqValid,
    input logic full
);

    int failCount = 0;   // failed assertions so far.

    // ####################
    // response pulse.
    // ####################

    respNotInReset: assert property (@(posedge clk) rst |-> !respValid)
        else begin
            $error("respValid high while rst is asserted");
            failCount++;
        end

    respOnePulse: assert property (@(posedge clk) disable iff (rst)
        respValid |=> !respValid)
        else begin
            $error("respValid lasted more than one cycle");
            failCount++;
        end

    // ####################
    // holder and queue.
    // ####################

    // slbEn high means the holder slot is free.
    mcEnIdle: assert property (@(posedge clk) disable iff (rst) slbEn |-> !mcEn)
        else begin
            $error("mcEn high while the holder is free");
            failCount++;
        end

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        full |-> !reqValid)
        else begin
            $error("reqValid driven while the queue is full");
            failCount++;
        end

endmodule

// File: lsuTop.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsuTop import lsuPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,
    input  logic     fetchBusy,
    input  logic     reqValid,
    input  memReq_t  reqIn,
    output logic     full,
    output logic     respValid,
    output memResp_t respOut
);

    logic               slbEn;
    logic               issueEn;
    memReq_t            issueReq;
    logic               mcEn;
    memReq_t            mcReq;
    logic               mcDone;
    logic [`DATA_W-1:0] mcData;
    logic               ramWe;
    logic [`ADDR_W-1:0] ramAddr;
    logic [7:0]         ramWdata;
    logic [7:0]         ramRdata;

    loadStoreQueue u_queue (
        .clk(clk), .rst(rst), .rdy(rdy),
        .reqValid(reqValid), .reqIn(reqIn), .full(full),
        .slbEn(slbEn), .issueEn(issueEn), .issueReq(issueReq)
    );

    dcache u_dcache (
        .clk(clk), .rst(rst), .rdy(rdy),
        .issueEn(issueEn), .issueReq(issueReq), .slbEn(slbEn),
        .mcEn(mcEn), .mcReq(mcReq), .mcDone(mcDone), .mcData(mcData),
        .respValid(respValid), .respOut(respOut)
    );

    memCtrl u_memCtrl (
        .clk(clk), .rst(rst), .rdy(rdy), .fetchBusy(fetchBusy),
        .mcEn(mcEn), .mcReq(mcReq), .mcDone(mcDone), .mcData(mcData),
        .ramWe(ramWe), .ramAddr(ramAddr), .ramWdata(ramWdata), .ramRdata(ramRdata)
    );

    dataRam u_ram (
        .clk(clk), .we(ramWe), .addr(ramAddr), .wdata(ramWdata), .rdata(ramRdata)
    );

endmodule

// File: dataRam.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module dataRam (
    input  logic               clk,
    input  logic               we,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [7:0]         wdata,
    output logic [7:0]         rdata
);

    localparam int IDX_W = $clog2(`RAM_BYTES);

    logic [7:0]       mem [`RAM_BYTES];
    logic [IDX_W-1:0] idx;

    assign idx = addr[IDX_W-1:0];   // wraps modulo the RAM size.

    // ####################
    // storage.
    // ####################

    initial begin
        for (int i = 0; i < `RAM_BYTES; i++) begin
            mem[i] = 8'h00;
        end
    end

    // read-first, one cycle latency.
    always @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
        rdata <= mem[idx];
    end

endmodule

// File: memCtrl.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module memCtrl import lsuPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               fetchBusy,

    input  logic               mcEn,
    input  memReq_t            mcReq,
    output logic               mcDone,
    output logic [`DATA_W-1:0] mcData,

    output logic               ramWe,
    output logic [`ADDR_W-1:0] ramAddr,
    output logic [7:0]         ramWdata,
    input  logic [7:0]         ramRdata
);

    mcState_t          state;
    logic [`LEN_W-1:0] cnt;       // current byte.
    logic [`LEN_W-1:0] byteIdx;
    logic [1:0]        capIdx;    // byte lane of the read in flight.
    logic              rdPend;    // read data arrives this cycle.
    logic              isLoad;
    logic              step;
    logic              issueRd;

    assign isLoad  = mcReq.op == OP_LOAD;
    assign step    = (state == MC_BYTE) && !fetchBusy;   // fetch owns the RAM otherwise.
    assign issueRd = step && isLoad && (cnt != mcReq.len);

    assign mcDone = state == MC_DONE;

    // ####################
    // RAM port.
    // ####################

    // while frozen, keep re-reading the pending byte so rdata stays valid.
    assign byteIdx  = (!rdy && rdPend) ? `LEN_W'(capIdx) : cnt;
    assign ramAddr  = mcReq.addr + {{(`ADDR_W-`LEN_W){1'b0}}, byteIdx};
    assign ramWe    = rdy && step && !isLoad;
    assign ramWdata = mcReq.data[{cnt[1:0], 3'b000} +: 8];

    // ####################
    // sequencer.
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= MC_IDLE;
            cnt    <= '0;
            rdPend <= 1'b0;
        end else if (rdy) begin
            rdPend <= issueRd;

            case (state)
                MC_IDLE: begin
                    // mcEn has already dropped by the time DONE falls back here.
                    if (mcEn) begin
                        state <= MC_BYTE;
                        cnt   <= '0;
                    end
                end
                MC_BYTE: begin
                    if (step) begin
                        if (isLoad) begin
                            if (cnt == mcReq.len) begin
                                state <= MC_DONE;   // last byte has landed.
                            end else begin
                                cnt <= cnt + 1'b1;
                            end
                        end else begin
                            if (cnt == mcReq.len - `LEN_W'(1)) begin
                                state <= MC_DONE;
                            end
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                MC_DONE: begin
                    state <= MC_IDLE;
                end
                default: begin
                    state <= MC_IDLE;
                end
            endcase
        end
    end

    // load data assembly, little-endian.
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (issueRd) begin
                capIdx <= cnt[1:0];
            end

            if (state == MC_IDLE && mcEn) begin
                mcData <= '0;   // zero-extend short loads.
            end else if (rdPend) begin
                mcData[{capIdx, 3'b000} +: 8] <= ramRdata;
            end
        end
    end

endmodule

// File: dcache.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module dcache import lsuPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,

    // from the request queue.
    input  logic               issueEn,
    input  memReq_t            issueReq,
    output logic               slbEn,

    // to the memory controller.
    output logic               mcEn,
    output memReq_t            mcReq,
    input  logic               mcDone,
    input  logic [`DATA_W-1:0] mcData,

    // completion.
    output logic               respValid,
    output memResp_t           respOut
);

    logic occupied;
    logic respQ;

    // accept a new request only when frozen path is running and the slot is empty.
    assign slbEn = rdy && !occupied;

    // a pending response waits out a stall and shows once rdy returns.
    assign respValid = respQ && rdy;

    // ####################
    // slot control.
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            mcEn     <= 1'b0;
            respQ    <= 1'b0;
        end else if (rdy) begin
            respQ <= 1'b0;

            if (mcDone) begin
                respQ    <= 1'b1;
                occupied <= 1'b0;
                mcEn     <= 1'b0;
            end

            // slbEn keeps this away from an occupied slot.
            if (issueEn) begin
                occupied <= 1'b1;
                mcEn     <= 1'b1;
            end
        end
    end

    // held request and response payload.
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (issueEn) begin
                mcReq <= issueReq;
            end

            if (mcDone) begin
                respOut.nick <= mcReq.nick;
                if (mcReq.op == OP_STORE) begin
                    respOut.data <= mcReq.data;   // stores echo their data.
                end else begin
                    respOut.data <= mcData;
                end
            end
        end
    end

endmodule

// File: loadStoreQueue.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module loadStoreQueue import lsuPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,

    input  logic    reqValid,
    input  memReq_t reqIn,
    output logic    full,

    input  logic    slbEn,
    output logic    issueEn,
    output memReq_t issueReq
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = `QUEUE_DEPTH;

    memReq_t          entries [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;    // one bit wider so a full queue is distinct.
    logic             push;
    logic             pop;
    logic             empty;

    assign empty = count == '0;
    assign full  = count == DEPTH_CNT;

    // slbEn is already low while the path is frozen.
    assign push = reqValid && rdy && !full;
    assign pop  = issueEn;

    assign issueEn  = !empty && slbEn;
    assign issueReq = entries[rdPtr];    // head of the queue.

    // ####################
    // pointers and count.
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (rdy) begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;   // wraps, depth is a power of two.
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end

            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage.
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= reqIn;
        end
    end

endmodule

// File: lsuPkg.sv
`include "lsu_params.svh"

package lsuPkg;

    // ####################
    // request and response types.
    // ####################

    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } lsOp_t;

    // 1 + 16 + 32 + 3 + 4 = 56 bits.
    typedef struct packed {
        lsOp_t                op;
        logic [`ADDR_W-1:0]   addr;
        logic [`DATA_W-1:0]   data;   // store data, unused on loads.
        logic [`LEN_W-1:0]    len;
        logic [`NICK_W-1:0]   nick;
    } memReq_t;

    // 32 + 4 = 36 bits.
    typedef struct packed {
        logic [`DATA_W-1:0]   data;
        logic [`NICK_W-1:0]   nick;
    } memResp_t;

    // memory controller sequencing.
    typedef enum logic [1:0] {
        MC_IDLE,
        MC_BYTE,
        MC_DONE
    } mcState_t;

endpackage

// File: lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// ####################
// memory path widths.
// ####################

`define ADDR_W 16       // byte address.
`define DATA_W 32       // widest access is one word.
`define LEN_W 3         // access length, 1, 2 or 4 bytes.
`define NICK_W 4        // request tag.

// ####################
// sizes.
// ####################

`define QUEUE_DEPTH 4   // must be a power of two.
`define RAM_BYTES 1024

`endif
